// ==== files.f ====
+incdir+hdl
hdl/enc_pkg.sv
hdl/tdm_rx.sv
hdl/sample_fifo.sv
hdl/tdm_tx.sv
hdl/enc_top.sv
sim/enc_checker.sv
sim/tb_enc.sv

// ==== hdl/enc_macros.svh ====
// encoder shared macros
`ifndef ENC_MACROS_SVH
`define ENC_MACROS_SVH

// --------------------------------------------------
// serial sample format
// --------------------------------------------------

// pcm sample width in bits
`define ENC_SAMPLE_W 8

// slots per tdm frame
`define ENC_NUM_SLOTS 4

// bits needed for a slot index
`define ENC_SLOT_W 2

// --------------------------------------------------
// buffering and output timing
// --------------------------------------------------

`define ENC_FIFO_DEPTH 16   // entries, power of two

// half period of output serial clock, in clk cycles
`define ENC_CLK_DIV 4

// a-law idle pattern, sent in slots with nothing pending
`define ENC_IDLE_CODE 8'hD5

`endif

// ==== hdl/enc_pkg.sv ====
// encoder data types
`default_nettype none

`include "enc_macros.svh"

package enc_pkg;

	// --------------------------------------------------
	// basic fields
	// --------------------------------------------------

	// one pcm sample as it travels on the serial line
	typedef logic [`ENC_SAMPLE_W-1:0] sample_t;

	// slot number within a frame
	typedef logic [`ENC_SLOT_W-1:0] slot_t;

	// --------------------------------------------------
	// payload of rx, buffer and tx
	// --------------------------------------------------

	// sample plus the slot it arrived in, slot in the upper bits
	typedef struct packed {
		slot_t   slot;   // input slot index
		sample_t data;   // pcm byte, msb first on the wire
	} tagged_sample_t;

endpackage

`default_nettype wire

// ==== hdl/enc_top.sv ====
// pcm encoder top
`default_nettype none

module enc_top (
	input  logic clk,
	input  logic i_rst,
	input  logic i_enc_s,      // serial pcm in
	input  logic i_enc_s_clk,  // input serial clock
	input  logic i_enc_s_fs,   // input frame sync
	output logic o_enc_o,      // serial pcm out
	output logic o_enc_o_clk,  // generated serial clock
	output logic o_enc_o_fs,   // generated frame sync
	output logic o_overrun     // buffer lost a sample
);

	// --------------------------------------------------
	// internal buses
	// --------------------------------------------------

	logic                    wr;       // rx push
	enc_pkg::tagged_sample_t wr_data;
	logic                    rd;       // tx pop
	enc_pkg::tagged_sample_t head;     // oldest buffered sample
	logic                    empty;

	// --------------------------------------------------
	// producer, buffer, consumer
	// --------------------------------------------------

	tdm_rx rx_inst0 (
		.clk         (clk),
		.i_rst       (i_rst),
		.i_enc_s     (i_enc_s),
		.i_enc_s_clk (i_enc_s_clk),
		.i_enc_s_fs  (i_enc_s_fs),
		.o_wr        (wr),
		.o_wr_data   (wr_data)
	);

	sample_fifo fifo_inst0 (
		.clk       (clk),
		.i_rst     (i_rst),
		.i_wr      (wr),
		.i_wr_data (wr_data),
		.i_rd      (rd),
		.o_rd_data (head),
		.o_empty   (empty),
		.o_full    (),          // rx has no back-pressure
		.o_overrun (o_overrun)
	);

	tdm_tx tx_inst0 (
		.clk         (clk),
		.i_rst       (i_rst),
		.i_head      (head),
		.i_empty     (empty),
		.o_rd        (rd),
		.o_enc_o     (o_enc_o),
		.o_enc_o_clk (o_enc_o_clk),
		.o_enc_o_fs  (o_enc_o_fs)
	);

endmodule

`default_nettype wire

// ==== hdl/sample_fifo.sv ====
// tagged sample fifo
`default_nettype none

`include "enc_macros.svh"

module sample_fifo #(
	parameter int DEPTH = `ENC_FIFO_DEPTH   // power of two, >= 2
) (
	input  logic                    clk,
	input  logic                    i_rst,
	input  logic                    i_wr,        // push strobe
	input  enc_pkg::tagged_sample_t i_wr_data,
	input  logic                    i_rd,        // pop strobe
	output enc_pkg::tagged_sample_t o_rd_data,   // head, combinational
	output logic                    o_empty,
	output logic                    o_full,
	output logic                    o_overrun    // sticky, write lost while full
);

	localparam int AW = $clog2(DEPTH);
	localparam logic [AW:0] FULL_CNT = (AW + 1)'(DEPTH);

	// --------------------------------------------------
	// storage and pointers
	// --------------------------------------------------

	enc_pkg::tagged_sample_t mem [DEPTH];

	logic [AW-1:0] wr_ptr;   // wraps at DEPTH
	logic [AW-1:0] rd_ptr;
	logic [AW:0]   count;    // occupancy, 0..DEPTH

	logic do_wr;
	logic do_rd;

	assign o_empty = (count == '0);
	assign o_full  = (count == FULL_CNT);

	assign do_wr = i_wr & ~o_full;   // dropped when full
	assign do_rd = i_rd & ~o_empty;

	assign o_rd_data = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (do_wr)
			mem[wr_ptr] <= i_wr_data;
	end

	// --------------------------------------------------
	// control
	// --------------------------------------------------

	always_ff @(posedge clk) begin
		if (i_rst) begin
			wr_ptr    <= '0;
			rd_ptr    <= '0;
			count     <= '0;
			o_overrun <= 1'b0;
		end else begin
			if (do_wr)
				wr_ptr <= wr_ptr + AW'(1);
			if (do_rd)
				rd_ptr <= rd_ptr + AW'(1);
			case ({do_wr, do_rd})
				2'b10:   count <= count + (AW + 1)'(1);
				2'b01:   count <= count - (AW + 1)'(1);
				default: count <= count;   // both or neither, no change
			endcase
			if (i_wr && o_full)
				o_overrun <= 1'b1;   // held until reset
		end
	end

endmodule

`default_nettype wire

// ==== hdl/tdm_rx.sv ====
// tdm input deserializer
`default_nettype none

`include "enc_macros.svh"

module tdm_rx (
	input  logic                    clk,
	input  logic                    i_rst,
	input  logic                    i_enc_s,      // serial data, async to clk
	input  logic                    i_enc_s_clk,  // serial clock, async to clk
	input  logic                    i_enc_s_fs,   // frame sync, async to clk
	output logic                    o_wr,         // one clk pulse per slot
	output enc_pkg::tagged_sample_t o_wr_data     // valid with o_wr
);

	localparam int SW = `ENC_SAMPLE_W;
	localparam int BIT_W = $clog2(SW);
	localparam logic [BIT_W-1:0] LAST_BIT = BIT_W'(SW - 1);
	localparam enc_pkg::slot_t LAST_SLOT = enc_pkg::slot_t'(`ENC_NUM_SLOTS - 1);

	// --------------------------------------------------
	// input synchronizers
	// --------------------------------------------------

	logic [1:0] s_sync;    // data
	logic [1:0] sclk_sync; // serial clock
	logic [1:0] fs_sync;   // frame sync
	logic       sclk_prev; // last synced clock level, for edge detect

	logic ser_rise;   // synced rising edge of serial clock
	logic ser_bit;
	logic ser_fs;

	always_ff @(posedge clk) begin
		if (i_rst) begin
			s_sync    <= '0;
			sclk_sync <= '0;
			fs_sync   <= '0;
			sclk_prev <= 1'b0;
		end else begin
			s_sync    <= {s_sync[0], i_enc_s};
			sclk_sync <= {sclk_sync[0], i_enc_s_clk};
			fs_sync   <= {fs_sync[0], i_enc_s_fs};
			sclk_prev <= sclk_sync[1];
		end
	end

	// data and fs go through the same two stages as the clock,
	// so they line up with the detected edge
	assign ser_rise = sclk_sync[1] & ~sclk_prev;
	assign ser_bit  = s_sync[1];
	assign ser_fs   = fs_sync[1];

	// --------------------------------------------------
	// frame tracking
	// --------------------------------------------------

	logic             active;    // inside a frame, slots left to collect
	logic [BIT_W-1:0] bit_cnt;   // next bit position within slot
	enc_pkg::slot_t   slot_cnt;  // slot being collected
	logic [SW-1:0]    shift;     // incoming bits, msb first
	logic [SW-1:0]    shift_nxt;

	logic take_bit;  // this edge carries a wanted bit
	logic last_bit;  // this edge completes a slot

	assign take_bit  = ser_rise & (ser_fs | active);
	assign last_bit  = ser_rise & ~ser_fs & active & (bit_cnt == LAST_BIT);
	assign shift_nxt = {shift[SW-2:0], ser_bit};

	always_ff @(posedge clk) begin
		if (i_rst) begin
			active   <= 1'b0;
			bit_cnt  <= '0;
			slot_cnt <= '0;
			o_wr     <= 1'b0;
		end else begin
			o_wr <= last_bit;   // lands one clk after the last bit edge
			if (ser_rise && ser_fs) begin
				// fs bit is the msb of slot 0, so one bit is already in
				active   <= 1'b1;
				bit_cnt  <= BIT_W'(1);
				slot_cnt <= '0;
			end else if (last_bit) begin
				bit_cnt  <= '0;
				slot_cnt <= slot_cnt + enc_pkg::slot_t'(1);
				if (slot_cnt == LAST_SLOT)
					active <= 1'b0;   // rest of frame ignored until next fs
			end else if (take_bit) begin
				bit_cnt <= bit_cnt + BIT_W'(1);
			end
		end
	end

	// shifter and output sample, no reset needed
	always_ff @(posedge clk) begin
		if (take_bit)
			shift <= shift_nxt;
		if (last_bit) begin
			o_wr_data.slot <= slot_cnt;
			o_wr_data.data <= shift_nxt;  // includes the lsb just sampled
		end
	end

endmodule

`default_nettype wire

// ==== hdl/tdm_tx.sv ====
// tdm output serializer and clock generator
`default_nettype none

`include "enc_macros.svh"

module tdm_tx (
	input  logic                    clk,
	input  logic                    i_rst,
	input  enc_pkg::tagged_sample_t i_head,      // fifo head
	input  logic                    i_empty,
	output logic                    o_rd,        // pop head, one clk
	output logic                    o_enc_o,     // serial data out
	output logic                    o_enc_o_clk, // serial clock out
	output logic                    o_enc_o_fs   // frame sync out
);

	localparam int SW = `ENC_SAMPLE_W;
	localparam int BIT_W = $clog2(SW);
	localparam logic [BIT_W-1:0] LAST_BIT = BIT_W'(SW - 1);
	localparam enc_pkg::slot_t LAST_SLOT = enc_pkg::slot_t'(`ENC_NUM_SLOTS - 1);
	localparam int DIV_W = $clog2(`ENC_CLK_DIV + 1);
	localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(`ENC_CLK_DIV - 1);
	localparam enc_pkg::sample_t IDLE = `ENC_IDLE_CODE;

	// --------------------------------------------------
	// serial clock divider
	// --------------------------------------------------

	logic [DIV_W-1:0] div_cnt;
	logic             div_tick;   // toggle point of output clock
	logic             ser_fall;   // output clock about to go low

	assign div_tick = (div_cnt == DIV_LAST);
	assign ser_fall = div_tick & o_enc_o_clk;

	always_ff @(posedge clk) begin
		if (i_rst) begin
			div_cnt     <= '0;
			o_enc_o_clk <= 1'b0;
		end else if (div_tick) begin
			div_cnt     <= '0;
			o_enc_o_clk <= ~o_enc_o_clk;
		end else begin
			div_cnt <= div_cnt + DIV_W'(1);
		end
	end

	// --------------------------------------------------
	// bit and slot position
	// --------------------------------------------------

	logic             run;        // first frame has started
	logic [BIT_W-1:0] bit_cnt;    // bit now on o_enc_o
	enc_pkg::slot_t   slot_cnt;   // slot now on o_enc_o
	enc_pkg::slot_t   next_slot;  // slot that starts at slot_start
	logic             slot_start; // falling edge that begins a slot
	logic             use_head;   // head belongs to the starting slot
	enc_pkg::sample_t load_val;   // byte to send in the starting slot
	logic [SW-1:0]    shreg;      // remaining bits of current slot

	assign slot_start = ser_fall & (~run | (bit_cnt == LAST_BIT));

	always_comb begin
		if (!run || slot_cnt == LAST_SLOT)
			next_slot = '0;   // new frame
		else
			next_slot = slot_cnt + enc_pkg::slot_t'(1);
	end

	// head waits in the buffer until its own slot comes round
	assign use_head = ~i_empty & (i_head.slot == next_slot);
	assign load_val = use_head ? i_head.data : IDLE;

	always_ff @(posedge clk) begin
		if (i_rst) begin
			run        <= 1'b0;
			bit_cnt    <= '0;
			slot_cnt   <= '0;
			o_enc_o    <= 1'b0;
			o_enc_o_fs <= 1'b0;
			o_rd       <= 1'b0;
		end else begin
			o_rd <= slot_start & use_head;   // pop only what was taken
			if (slot_start) begin
				run        <= 1'b1;
				bit_cnt    <= '0;
				slot_cnt   <= next_slot;
				o_enc_o    <= load_val[SW-1];        // msb first
				o_enc_o_fs <= (next_slot == '0);     // msb of slot 0 only
			end else if (ser_fall) begin
				bit_cnt    <= bit_cnt + BIT_W'(1);
				o_enc_o    <= shreg[SW-1];
				o_enc_o_fs <= 1'b0;
			end
		end
	end

	// shifter, loaded at slot start, no reset
	always_ff @(posedge clk) begin
		if (slot_start)
			shreg <= {load_val[SW-2:0], 1'b0};   // msb already driven
		else if (ser_fall)
			shreg <= {shreg[SW-2:0], 1'b0};
	end

endmodule

`default_nettype wire

// ==== sim/enc_checker.sv ====
// sample fifo checker
`default_nettype none

`include "enc_macros.svh"

module enc_checker #(
	parameter int DEPTH = `ENC_FIFO_DEPTH
) (
	input logic                   clk,
	input logic                   i_rst,
	input logic                   i_empty,
	input logic                   i_full,
	input logic                   i_rd,     // pop strobe from tx
	input logic [$clog2(DEPTH):0] i_count   // fifo occupancy
);

	int fail_cnt = 0;   // assertion failures so far

	// --------------------------------------------------
	// buffer rules
	// --------------------------------------------------

	a_flags_exclusive : assert property (@(posedge clk) disable iff (i_rst)
		!(i_empty && i_full))
	else begin
		fail_cnt++;
		$error("fifo reports empty and full at once");
	end

	// tx may only pop a sample that is there
	a_no_pop_empty : assert property (@(posedge clk) disable iff (i_rst)
		i_rd |-> !i_empty)
	else begin
		fail_cnt++;
		$error("fifo popped while empty");
	end

	a_count_bound : assert property (@(posedge clk) disable iff (i_rst)
		i_count <= DEPTH)
	else begin
		fail_cnt++;
		$error("fifo occupancy above depth");
	end

endmodule

bind sample_fifo enc_checker #(.DEPTH(DEPTH)) fifo_chk (
	.clk     (clk),
	.i_rst   (i_rst),
	.i_empty (o_empty),
	.i_full  (o_full),
	.i_rd    (i_rd),
	.i_count (count)
);

`default_nettype wire

// ==== sim/tb_enc.sv ====
// pcm encoder testbench
`default_nettype none

`include "enc_macros.svh"

module tb_enc;

	localparam int SW = `ENC_SAMPLE_W;
	localparam int NSLOT = `ENC_NUM_SLOTS;
	localparam int BIT_CLKS = 2 * `ENC_CLK_DIV;         // clk per output bit
	localparam int FRAME_CLKS = NSLOT * SW * BIT_CLKS;  // clk per output frame
	localparam int N_SLOW = 6;
	localparam int SLOW_HOLD = 6;   // clk per input clock level, below output rate
	localparam int N_FAST = 40;
	localparam int FAST_HOLD = 3;   // above output rate, fills the fifo
	localparam int SETUP_CLKS = 4 + 3 * FRAME_CLKS;
	localparam int SLOW_CLKS = N_SLOW * NSLOT * SW * 2 * SLOW_HOLD + 2 * FRAME_CLKS;
	localparam int FAST_CLKS = N_FAST * NSLOT * SW * 2 * FAST_HOLD
		+ (`ENC_FIFO_DEPTH / NSLOT + 3) * FRAME_CLKS;
	localparam int TIMEOUT_CLKS = 3 * (SETUP_CLKS + SLOW_CLKS + FAST_CLKS);
	localparam enc_pkg::sample_t IDLE = `ENC_IDLE_CODE;

	logic clk;
	logic rst;
	logic enc_s;
	logic enc_s_clk;
	logic enc_s_fs;
	logic o_enc_o;
	logic o_enc_o_clk;
	logic o_enc_o_fs;
	logic o_overrun;

	integer seed;
	string  test_name;
	int     cycle = 0;
	int     rel_cycle = 0;   // cycle at reset release
	bit     strict;          // slow phase, exact order expected
	int     got_base;

	enc_pkg::tagged_sample_t model_q[$];   // sent, not yet seen at output

	enc_top dut (
		.clk         (clk),
		.i_rst       (rst),
		.i_enc_s     (enc_s),
		.i_enc_s_clk (enc_s_clk),
		.i_enc_s_fs  (enc_s_fs),
		.o_enc_o     (o_enc_o),
		.o_enc_o_clk (o_enc_o_clk),
		.o_enc_o_fs  (o_enc_o_fs),
		.o_overrun   (o_overrun)
	);

	initial clk = 1'b0;
	always #2 clk = ~clk;

	// --------------------------------------------------
	// reporting
	// --------------------------------------------------

	task automatic stop_with_fail(input string msg);
		$display("%s", msg);
		$display("** FAIL **");
		$fatal(1, "simulation stopped at first error");
	endtask

	task automatic check_eq(input string name, input int exp, input int act, input string what);
		assert (exp == act)
		else stop_with_fail($sformatf("** Error %s %s expected %0h actual %0h",
			name, what, exp, act));
	endtask

	always @(posedge clk) begin
		cycle <= cycle + 1;
		if (cycle >= TIMEOUT_CLKS)
			stop_with_fail($sformatf("run did not finish within %0d clk cycles", TIMEOUT_CLKS));
	end

	// --------------------------------------------------
	// serial driver
	// --------------------------------------------------

	function automatic enc_pkg::sample_t random_sample();
		enc_pkg::sample_t d;
		do
			d = enc_pkg::sample_t'($random(seed));
		while (d == IDLE);   // idle code would read as empty slot
		return d;
	endfunction

	task automatic send_frame(input int hold);
		enc_pkg::tagged_sample_t ts;
		for (int sl = 0; sl < NSLOT; sl++) begin
			ts.slot = enc_pkg::slot_t'(sl);
			ts.data = random_sample();
			model_q.push_back(ts);
			for (int b = SW - 1; b >= 0; b--) begin
				enc_s_clk = 1'b0;
				enc_s     = ts.data[b];   // msb first
				enc_s_fs  = (sl == 0) && (b == SW - 1);
				repeat (hold) @(negedge clk);
				enc_s_clk = 1'b1;         // rx samples here
				repeat (hold) @(negedge clk);
			end
		end
	endtask

	// --------------------------------------------------
	// output decoder and model compare
	// --------------------------------------------------

	logic             oclk_prev = 1'b0;
	logic             fs_prev = 1'b0;
	bit               aligned = 1'b0;   // seen first fs
	bit               oclk_seen = 1'b0;
	int               oclk_last = 0;    // cycle of last output clock rise
	int               bit_idx = 0;
	int               slot_idx = 0;
	enc_pkg::sample_t shift_in = '0;
	int               idle_run = 0;     // idle slots in a row
	int               got_cnt = 0;
	int               frame_cnt = 0;
	int               fs_cnt = 0;
	int               fs_last = 0;      // cycle of last fs rise
	int               fs_first = 0;     // cycle of first fs rise

	task automatic take_slot(input int slot, input enc_pkg::sample_t data);
		enc_pkg::tagged_sample_t got;
		enc_pkg::tagged_sample_t exp;
		bit found;
		got.slot = enc_pkg::slot_t'(slot);
		got.data = data;
		found    = 1'b0;
		if (data == IDLE) begin
			idle_run++;
		end else begin
			idle_run = 0;
			got_cnt++;
			if (strict) begin
				assert (model_q.size() > 0)
				else stop_with_fail("output carried a sample while none was pending");
				exp = model_q.pop_front();
				check_eq(test_name, exp, got, "slot/data");
			end else begin
				// drop entries lost to overrun until the match
				while (!found && model_q.size() > 0) begin
					exp   = model_q.pop_front();
					found = (exp == got);
				end
				assert (found)
				else stop_with_fail($sformatf("output sample %0h was never sent or is out of order",
					got));
			end
		end
	endtask

	always @(negedge clk) begin
		enc_pkg::sample_t byte_now;
		if (!rst && o_enc_o_clk && !oclk_prev) begin   // output clock rise
			if (oclk_seen)
				check_eq("oclk_period", BIT_CLKS, cycle - oclk_last, "output clock period");
			oclk_seen = 1'b1;
			oclk_last = cycle;
			if (o_enc_o_fs) begin
				assert (!aligned || (bit_idx == 0 && slot_idx == 0))
				else stop_with_fail("output frame sync inside a frame");
				aligned  = 1'b1;
				bit_idx  = 0;
				slot_idx = 0;
			end else begin
				assert (!aligned || bit_idx != 0 || slot_idx != 0)
				else stop_with_fail("output frame sync missing at frame start");
			end
			if (aligned) begin
				byte_now = {shift_in[SW-2:0], o_enc_o};
				shift_in = byte_now;
				bit_idx++;
				if (bit_idx == SW) begin
					take_slot(slot_idx, byte_now);
					bit_idx = 0;
					slot_idx++;
					if (slot_idx == NSLOT) begin
						slot_idx = 0;
						frame_cnt++;
					end
				end
			end
		end
		oclk_prev = o_enc_o_clk;
	end

	// fs period and width in clk cycles
	always @(negedge clk) begin
		if (!rst && o_enc_o_fs && !fs_prev) begin
			if (fs_cnt > 0)
				check_eq("fs_spacing", FRAME_CLKS, cycle - fs_last, "frame period");
			else
				fs_first = cycle;
			fs_last = cycle;
			fs_cnt++;
		end
		if (!rst && !o_enc_o_fs && fs_prev)
			check_eq("fs_width", BIT_CLKS, cycle - fs_last, "fs high time");
		fs_prev = o_enc_o_fs;
	end

	// --------------------------------------------------
	// test sequence
	// --------------------------------------------------

	initial begin
		seed      = 6;
		rst       = 1'b1;
		enc_s     = 1'b0;
		enc_s_clk = 1'b0;
		enc_s_fs  = 1'b0;
		strict    = 1'b1;
		got_base  = 0;
		test_name = "reset";
		repeat (4) @(negedge clk);
		rst       = 1'b0;
		rel_cycle = cycle;
		@(negedge clk);
		check_eq(test_name, 0, o_enc_o, "o_enc_o");
		check_eq(test_name, 0, o_enc_o_clk, "o_enc_o_clk");
		check_eq(test_name, 0, o_enc_o_fs, "o_enc_o_fs");
		check_eq(test_name, 0, o_overrun, "o_overrun");

		test_name = "idle_start";   // nothing sent yet
		while (frame_cnt < 2) @(negedge clk);
		// first output clock fall comes two divider periods after reset
		check_eq(test_name, BIT_CLKS, fs_first - rel_cycle, "first fs delay");

		test_name = "slow_in_order";
		repeat (N_SLOW) send_frame(SLOW_HOLD);
		while (model_q.size() > 0) @(negedge clk);   // every slot must come out
		check_eq(test_name, 0, o_overrun, "o_overrun");

		test_name = "fast_overrun";
		strict    = 1'b0;
		got_base  = got_cnt;
		repeat (N_FAST) send_frame(FAST_HOLD);
		repeat (4 * FAST_HOLD) @(negedge clk);       // rx sync latency
		while (idle_run < 2 * NSLOT) @(negedge clk); // two idle frames, buffer drained
		check_eq(test_name, 1, o_overrun, "o_overrun");
		assert (got_cnt > got_base)
		else stop_with_fail("no sample came out during the fast burst");
		assert (got_cnt - got_base < N_FAST * NSLOT)
		else stop_with_fail("overrun flagged but no sample was lost");

		if (dut.fifo_inst0.fifo_chk.fail_cnt == 0) begin
			$display("** PASS **");
			$finish;
		end else begin
			stop_with_fail("fifo checker assertions failed during the run");
		end
	end

endmodule

`default_nettype wire
